// ==== logic/mips_consts.svh ====
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// Datapath widths
`define MIPS_XLEN           32
`define MIPS_REG_AW         5
`define MIPS_DMEM_WORDS     64
`define MIPS_RESET_PC       32'h0000_0000

// Primary opcodes, instr[31:26]
`define MIPS_OP_RTYPE       6'd0
`define MIPS_OP_ADDI        6'd8
`define MIPS_OP_LW          6'd35
`define MIPS_OP_SW          6'd43
`define MIPS_OP_BEQ         6'd4

// R-type funct field, instr[5:0]
`define MIPS_FN_ADD         6'd32
`define MIPS_FN_SUB         6'd34
`define MIPS_FN_AND         6'd36
`define MIPS_FN_OR          6'd37
`define MIPS_FN_SLT         6'd42

// ALU operation encodings
`define MIPS_ALU_OP_W       3
`define MIPS_ALU_ADD        3'd0
`define MIPS_ALU_SUB        3'd1
`define MIPS_ALU_AND        3'd2
`define MIPS_ALU_OR         3'd3
`define MIPS_ALU_SLT        3'd4

// ALU class from the control unit
`define MIPS_ALU_CLS_W      2
`define MIPS_CLS_ADD        2'd0
`define MIPS_CLS_SUB        2'd1
`define MIPS_CLS_FUNCT      2'd2

// Operand source selects
`define MIPS_FWD_W          2
`define MIPS_FWD_REG        2'd0
`define MIPS_FWD_EXMEM      2'd1
`define MIPS_FWD_MEMWB      2'd2

`endif

// ==== logic/mips_pkg.sv ====
`default_nettype none
`include "mips_consts.svh"

package mips_pkg;

    typedef logic [`MIPS_XLEN-1:0]      word_t;
    typedef logic [`MIPS_XLEN-1:0]      instr_t;
    typedef logic [`MIPS_REG_AW-1:0]    reg_addr_t;
    typedef logic [`MIPS_ALU_OP_W-1:0]  alu_op_t;
    typedef logic [`MIPS_ALU_CLS_W-1:0] alu_class_t;
    typedef logic [`MIPS_FWD_W-1:0]     fwd_sel_t;

    // Decoded control, carried down the pipe
    typedef struct packed {
        logic       reg_write;
        logic       mem_to_reg;
        logic       mem_read;
        logic       mem_write;
        logic       branch;
        logic       alu_src;
        logic       reg_dst;
        alu_class_t alu_class;
    } ctrl_t;

    ////////////////////////////////////////
    // Stage registers
    ////////////////////////////////////////
    typedef struct packed {
        word_t  pc4;
        instr_t instr;
    } if_id_t;

    typedef struct packed {
        ctrl_t      ctrl;
        word_t      pc4;
        word_t      rs_data;
        word_t      rt_data;
        word_t      imm;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [5:0] funct;
    } id_ex_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     branch_target;
        logic      zero;
        word_t     result;
        word_t     store_data;
        reg_addr_t dest;
    } ex_mem_t;

    // Only the writeback controls survive into the last stage
    typedef struct packed {
        logic      reg_write;
        logic      mem_to_reg;
        word_t     result;
        word_t     load_data;
        reg_addr_t dest;
    } mem_wb_t;

endpackage

`default_nettype wire

// ==== logic/mips_decode.sv ====
`default_nettype none
`include "mips_consts.svh"

module mips_decode import mips_pkg::*; (
    input  wire instr_t i_instr,
    output ctrl_t       o_ctrl,
    output word_t       o_imm
);

    logic [5:0] opcode;
    reg_addr_t  rt;
    reg_addr_t  rd;
    reg_addr_t  dest;
    ctrl_t      ctrl_raw;

    assign opcode = i_instr[31:26];
    assign rt     = i_instr[20:16];
    assign rd     = i_instr[15:11];

    ////////////////////////////////////////
    // Control unit
    ////////////////////////////////////////
    always_comb begin
        ctrl_raw = '0;
        case (opcode)
            `MIPS_OP_RTYPE: begin
                ctrl_raw.reg_write = 1'b1;
                ctrl_raw.reg_dst   = 1'b1;
                ctrl_raw.alu_class = `MIPS_CLS_FUNCT;
            end
            `MIPS_OP_ADDI: begin
                ctrl_raw.reg_write = 1'b1;
                ctrl_raw.alu_src   = 1'b1;
                ctrl_raw.alu_class = `MIPS_CLS_ADD;
            end
            `MIPS_OP_LW: begin
                ctrl_raw.reg_write  = 1'b1;
                ctrl_raw.mem_to_reg = 1'b1;
                ctrl_raw.mem_read   = 1'b1;
                ctrl_raw.alu_src    = 1'b1;
                ctrl_raw.alu_class  = `MIPS_CLS_ADD;
            end
            `MIPS_OP_SW: begin
                ctrl_raw.mem_write = 1'b1;
                ctrl_raw.alu_src   = 1'b1;
                ctrl_raw.alu_class = `MIPS_CLS_ADD;
            end
            `MIPS_OP_BEQ: begin
                ctrl_raw.branch    = 1'b1;
                ctrl_raw.alu_class = `MIPS_CLS_SUB;
            end
            // Anything else retires as a bubble
            default: ctrl_raw = '0;
        endcase
    end

    // $zero is never written, so the strobe stays quiet for it
    assign dest = ctrl_raw.reg_dst ? rd : rt;

    always_comb begin
        o_ctrl = ctrl_raw;
        if (dest == '0) begin
            o_ctrl.reg_write = 1'b0;
        end
    end

    assign o_imm = {{(`MIPS_XLEN-16){i_instr[15]}}, i_instr[15:0]};

endmodule

`default_nettype wire

// ==== logic/mips_regfile.sv ====
`default_nettype none
`include "mips_consts.svh"

module mips_regfile import mips_pkg::*; (
    input  wire            i_clk,
    input  wire            i_rst_n,
    input  wire            i_we,
    input  wire reg_addr_t i_wr_addr,
    input  wire word_t     i_wr_data,
    input  wire reg_addr_t i_rs_addr,
    input  wire reg_addr_t i_rt_addr,
    output word_t          o_rs_data,
    output word_t          o_rt_data
);

    localparam int NREGS = 1 << `MIPS_REG_AW;

    word_t regs [NREGS];

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_wr_addr != '0)) begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    // Write-through, so decode sees the value retiring this cycle
    function automatic word_t read_port(input reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (i_we && (addr == i_wr_addr)) begin
            return i_wr_data;
        end
        return regs[addr];
    endfunction

    always_comb begin
        o_rs_data = read_port(i_rs_addr);
        o_rt_data = read_port(i_rt_addr);
    end

endmodule

`default_nettype wire

// ==== logic/mips_hazard.sv ====
`default_nettype none
`include "mips_consts.svh"

module mips_hazard import mips_pkg::*; (
    input  wire reg_addr_t i_id_rs,
    input  wire reg_addr_t i_id_rt,
    input  wire id_ex_t    i_id_ex,
    input  wire ex_mem_t   i_ex_mem,
    input  wire mem_wb_t   i_mem_wb,
    output logic           o_stall,
    output logic           o_flush,
    output fwd_sel_t       o_fwd_a,
    output fwd_sel_t       o_fwd_b
);

    ////////////////////////////////////////
    // Load-use and branch
    ////////////////////////////////////////

    // Load destination is always rt
    assign o_stall = i_id_ex.ctrl.mem_read && i_id_ex.ctrl.reg_write &&
                     ((i_id_ex.rt == i_id_rs) || (i_id_ex.rt == i_id_rt));

    // beq resolves one stage late, in MEM
    assign o_flush = i_ex_mem.ctrl.branch && i_ex_mem.zero;

    ////////////////////////////////////////
    // Forwarding
    ////////////////////////////////////////
    function automatic fwd_sel_t fwd_for(
        input reg_addr_t src,
        input logic      exm_we,
        input reg_addr_t exm_dest,
        input logic      wb_we,
        input reg_addr_t wb_dest
    );
        // Youngest producer wins
        if (exm_we && (exm_dest == src)) begin
            return `MIPS_FWD_EXMEM;
        end
        if (wb_we && (wb_dest == src)) begin
            return `MIPS_FWD_MEMWB;
        end
        return `MIPS_FWD_REG;
    endfunction

    assign o_fwd_a = fwd_for(i_id_ex.rs, i_ex_mem.ctrl.reg_write, i_ex_mem.dest,
                             i_mem_wb.reg_write, i_mem_wb.dest);
    assign o_fwd_b = fwd_for(i_id_ex.rt, i_ex_mem.ctrl.reg_write, i_ex_mem.dest,
                             i_mem_wb.reg_write, i_mem_wb.dest);

endmodule

`default_nettype wire

// ==== logic/mips_execute.sv ====
`default_nettype none
`include "mips_consts.svh"

module mips_execute import mips_pkg::*; (
    input  wire id_ex_t   i_id_ex,
    input  wire fwd_sel_t i_fwd_a,
    input  wire fwd_sel_t i_fwd_b,
    input  wire word_t    i_ex_mem_result,
    input  wire word_t    i_wb_data,
    output word_t         o_result,
    output word_t         o_store_data,
    output word_t         o_branch_target,
    output logic          o_zero,
    output reg_addr_t     o_dest
);

    alu_op_t alu_op;
    word_t   op_a;
    word_t   op_b_reg;
    word_t   op_b;
    logic    a_lt_b;

    ////////////////////////////////////////
    // ALU control
    ////////////////////////////////////////
    always_comb begin
        case (i_id_ex.ctrl.alu_class)
            `MIPS_CLS_SUB: alu_op = `MIPS_ALU_SUB;
            `MIPS_CLS_FUNCT: begin
                case (i_id_ex.funct)
                    `MIPS_FN_SUB: alu_op = `MIPS_ALU_SUB;
                    `MIPS_FN_AND: alu_op = `MIPS_ALU_AND;
                    `MIPS_FN_OR:  alu_op = `MIPS_ALU_OR;
                    `MIPS_FN_SLT: alu_op = `MIPS_ALU_SLT;
                    default:      alu_op = `MIPS_ALU_ADD;
                endcase
            end
            default: alu_op = `MIPS_ALU_ADD;
        endcase
    end

    // Forwarding muxes
    function automatic word_t pick(input fwd_sel_t sel, input word_t reg_val,
                                   input word_t exm_val, input word_t wb_val);
        case (sel)
            `MIPS_FWD_EXMEM: return exm_val;
            `MIPS_FWD_MEMWB: return wb_val;
            default:         return reg_val;
        endcase
    endfunction

    assign op_a     = pick(i_fwd_a, i_id_ex.rs_data, i_ex_mem_result, i_wb_data);
    assign op_b_reg = pick(i_fwd_b, i_id_ex.rt_data, i_ex_mem_result, i_wb_data);
    assign op_b     = i_id_ex.ctrl.alu_src ? i_id_ex.imm : op_b_reg;

    ////////////////////////////////////////
    // ALU
    ////////////////////////////////////////
    assign a_lt_b = $signed(op_a) < $signed(op_b);

    always_comb begin
        case (alu_op)
            `MIPS_ALU_SUB: o_result = op_a - op_b;
            `MIPS_ALU_AND: o_result = op_a & op_b;
            `MIPS_ALU_OR:  o_result = op_a | op_b;
            `MIPS_ALU_SLT: o_result = {{(`MIPS_XLEN-1){1'b0}}, a_lt_b};
            default:       o_result = op_a + op_b;
        endcase
    end

    assign o_zero       = (o_result == '0);
    // sw stores the forwarded rt, not the immediate
    assign o_store_data = op_b_reg;

    assign o_branch_target = i_id_ex.pc4 + {i_id_ex.imm[`MIPS_XLEN-3:0], 2'b00};
    assign o_dest          = i_id_ex.ctrl.reg_dst ? i_id_ex.rd : i_id_ex.rt;

endmodule

`default_nettype wire

// ==== logic/mips_dmem.sv ====
`default_nettype none
`include "mips_consts.svh"

module mips_dmem import mips_pkg::*; (
    input  wire        i_clk,
    input  wire        i_we,
    input  wire word_t i_addr,
    input  wire word_t i_wdata,
    output word_t      o_rdata
);

    localparam int AW = $clog2(`MIPS_DMEM_WORDS);

    word_t          mem [`MIPS_DMEM_WORDS];
    logic [AW-1:0]  idx;

    // Word index, byte offset dropped
    assign idx = i_addr[AW+1:2];

    always_ff @(posedge i_clk) begin
        if (i_we) begin
            mem[idx] <= i_wdata;
        end
    end

    assign o_rdata = mem[idx];

endmodule

`default_nettype wire

// ==== logic/mips_core.sv ====
`default_nettype none
`include "mips_consts.svh"

module mips_core import mips_pkg::*; (
    input  wire         basys_clk,
    input  wire         i_rst_n,
    output word_t       o_imem_addr,
    input  wire instr_t i_imem_instr,
    output logic        o_wb_we,
    output reg_addr_t   o_wb_rd,
    output word_t       o_wb_data
);

    word_t     pc;
    word_t     pc4;
    if_id_t    if_id;
    id_ex_t    id_ex;
    id_ex_t    id_ex_d;
    ex_mem_t   ex_mem;
    ex_mem_t   ex_mem_d;
    mem_wb_t   mem_wb;
    mem_wb_t   mem_wb_d;

    ctrl_t     id_ctrl;
    word_t     id_imm;
    reg_addr_t id_rs;
    reg_addr_t id_rt;
    word_t     id_rs_data;
    word_t     id_rt_data;

    logic      stall;
    logic      flush;
    fwd_sel_t  fwd_a;
    fwd_sel_t  fwd_b;

    word_t     ex_result;
    word_t     ex_store_data;
    word_t     ex_branch_target;
    logic      ex_zero;
    reg_addr_t ex_dest;

    word_t     dmem_rdata;
    word_t     wb_data;

    ////////////////////////////////////////
    // Fetch
    ////////////////////////////////////////
    assign pc4         = pc + 32'd4;
    assign o_imem_addr = pc;

    // A taken branch overrides a pending stall
    always_ff @(posedge basys_clk) begin
        if (!i_rst_n) begin
            pc <= `MIPS_RESET_PC;
        end else if (flush) begin
            pc <= ex_mem.branch_target;
        end else if (!stall) begin
            pc <= pc4;
        end
    end

    always_ff @(posedge basys_clk) begin
        if (!i_rst_n || flush) begin
            if_id <= '0;
        end else if (!stall) begin
            if_id.pc4   <= pc4;
            if_id.instr <= i_imem_instr;
        end
    end

    ////////////////////////////////////////
    // Decode
    ////////////////////////////////////////
    assign id_rs = if_id.instr[25:21];
    assign id_rt = if_id.instr[20:16];

    mips_decode u_decode (
        .i_instr    (if_id.instr),
        .o_ctrl     (id_ctrl),
        .o_imm      (id_imm)
    );

    mips_regfile u_regfile (
        .i_clk      (basys_clk),
        .i_rst_n    (i_rst_n),
        .i_we       (mem_wb.reg_write),
        .i_wr_addr  (mem_wb.dest),
        .i_wr_data  (wb_data),
        .i_rs_addr  (id_rs),
        .i_rt_addr  (id_rt),
        .o_rs_data  (id_rs_data),
        .o_rt_data  (id_rt_data)
    );

    mips_hazard u_hazard (
        .i_id_rs    (id_rs),
        .i_id_rt    (id_rt),
        .i_id_ex    (id_ex),
        .i_ex_mem   (ex_mem),
        .i_mem_wb   (mem_wb),
        .o_stall    (stall),
        .o_flush    (flush),
        .o_fwd_a    (fwd_a),
        .o_fwd_b    (fwd_b)
    );

    always_comb begin
        id_ex_d.ctrl    = id_ctrl;
        id_ex_d.pc4     = if_id.pc4;
        id_ex_d.rs_data = id_rs_data;
        id_ex_d.rt_data = id_rt_data;
        id_ex_d.imm     = id_imm;
        id_ex_d.rs      = id_rs;
        id_ex_d.rt      = id_rt;
        id_ex_d.rd      = if_id.instr[15:11];
        id_ex_d.funct   = if_id.instr[5:0];
    end

    // Bubble on load-use or flush
    always_ff @(posedge basys_clk) begin
        if (!i_rst_n || flush || stall) begin
            id_ex <= '0;
        end else begin
            id_ex <= id_ex_d;
        end
    end

    ////////////////////////////////////////
    // Execute
    ////////////////////////////////////////
    mips_execute u_execute (
        .i_id_ex            (id_ex),
        .i_fwd_a            (fwd_a),
        .i_fwd_b            (fwd_b),
        .i_ex_mem_result    (ex_mem.result),
        .i_wb_data          (wb_data),
        .o_result           (ex_result),
        .o_store_data       (ex_store_data),
        .o_branch_target    (ex_branch_target),
        .o_zero             (ex_zero),
        .o_dest             (ex_dest)
    );

    always_comb begin
        ex_mem_d.ctrl          = id_ex.ctrl;
        ex_mem_d.branch_target = ex_branch_target;
        ex_mem_d.zero          = ex_zero;
        ex_mem_d.result        = ex_result;
        ex_mem_d.store_data    = ex_store_data;
        ex_mem_d.dest          = ex_dest;
    end

    always_ff @(posedge basys_clk) begin
        if (!i_rst_n || flush) begin
            ex_mem <= '0;
        end else begin
            ex_mem <= ex_mem_d;
        end
    end

    ////////////////////////////////////////
    // Memory and writeback
    ////////////////////////////////////////
    mips_dmem u_dmem (
        .i_clk      (basys_clk),
        .i_we       (ex_mem.ctrl.mem_write),
        .i_addr     (ex_mem.result),
        .i_wdata    (ex_mem.store_data),
        .o_rdata    (dmem_rdata)
    );

    always_comb begin
        mem_wb_d.reg_write  = ex_mem.ctrl.reg_write;
        mem_wb_d.mem_to_reg = ex_mem.ctrl.mem_to_reg;
        mem_wb_d.result     = ex_mem.result;
        mem_wb_d.load_data  = dmem_rdata;
        mem_wb_d.dest       = ex_mem.dest;
    end

    always_ff @(posedge basys_clk) begin
        if (!i_rst_n) begin
            mem_wb <= '0;
        end else begin
            mem_wb <= mem_wb_d;
        end
    end

    assign wb_data   = mem_wb.mem_to_reg ? mem_wb.load_data : mem_wb.result;
    assign o_wb_we   = mem_wb.reg_write;
    assign o_wb_rd   = mem_wb.dest;
    assign o_wb_data = wb_data;

endmodule

`default_nettype wire

// ==== testbench/mips_checker.sv ====
`default_nettype none

module mips_checker import mips_pkg::*; (
    input wire            i_clk,
    input wire            i_rst_n,
    input wire word_t     i_imem_addr,
    input wire            i_wb_we,
    input wire reg_addr_t i_wb_rd
);

    timeunit 1ns;
    timeprecision 1ps;

    // Failure tallies, read by the testbench at the end
    int n_reset_fail = 0;
    int n_wb_rd_fail = 0;
    int n_pc_fail    = 0;

    // Pipeline is empty in reset and in the cycle right after it
    wb_quiet_in_reset: assert property (@(posedge i_clk) $past(!i_rst_n) |-> !i_wb_we)
        else begin
            $error("write strobe seen during or right after reset");
            n_reset_fail++;
        end

    // $zero never retires as a write
    wb_rd_nonzero: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_wb_we |-> (i_wb_rd != '0))
        else begin
            $error("write strobe for register 0");
            n_wb_rd_fail++;
        end

    pc_aligned: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !$isunknown(i_imem_addr) && (i_imem_addr[1:0] == 2'b00))
        else begin
            $error("fetch address %h unknown or not word aligned", i_imem_addr);
            n_pc_fail++;
        end

endmodule

`default_nettype wire

// ==== testbench/tb_mips_core.sv ====
`default_nettype none
`include "mips_consts.svh"

module tb_mips_core import mips_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int ROM_WORDS    = 64;
    localparam int RESET_CYCLES = 8;
    localparam int TAIL_CYCLES  = 8;

    logic      clk;
    logic      rst_n;
    instr_t    imem_instr = '0;
    word_t     imem_addr;
    logic      wb_we;
    reg_addr_t wb_rd;
    word_t     wb_data;

    instr_t    rom [ROM_WORDS];
    instr_t    prog [$];
    reg_addr_t exp_rd [$];
    word_t     exp_data [$];
    int        errors      = 0;
    int        test_errors = 0;
    int        tests_run   = 0;
    int        cycle_count = 0;
    // Grows by five cycles per instruction plus 40 per test
    int        cycle_limit = 16;
    int        seed        = 32'h7881_4c59;

    mips_core mips_core_i (
        .basys_clk      (clk),
        .i_rst_n        (rst_n),
        .o_imem_addr    (imem_addr),
        .i_imem_instr   (imem_instr),
        .o_wb_we        (wb_we),
        .o_wb_rd        (wb_rd),
        .o_wb_data      (wb_data)
    );

    bind mips_core mips_checker u_checker (
        .i_clk          (basys_clk),
        .i_rst_n        (i_rst_n),
        .i_imem_addr    (o_imem_addr),
        .i_wb_we        (o_wb_we),
        .i_wb_rd        (o_wb_rd)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: run went past its limit of %0d cycles", cycle_limit);
            $display("Finished with errors");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Instruction ROM
    ////////////////////////////////////////
    // Past the program it answers nops
    function automatic instr_t rom_read(input word_t addr);
        int idx;
        idx = int'(addr >> 2);
        if (idx < ROM_WORDS) begin
            return rom[idx];
        end
        return '0;
    endfunction

    always @(negedge clk) begin
        imem_instr <= rom_read(imem_addr);
    end

    task automatic load_rom();
        foreach (rom[i]) begin
            if (i < prog.size()) begin
                rom[i] = prog[i];
            end else begin
                rom[i] = '0;
            end
        end
    endtask

    // Assembler helpers
    function automatic instr_t rtype(input logic [5:0] fn, input int rd, input int rs,
                                     input int rt);
        return {`MIPS_OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
    endfunction

    function automatic instr_t itype(input logic [5:0] op, input int rt, input int rs,
                                     input int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    task automatic emit(input instr_t ins);
        prog.push_back(ins);
    endtask

    ////////////////////////////////////////
    // Sequential ISA model
    ////////////////////////////////////////
    task automatic build_expected();
        word_t     regs [32];
        word_t     dmem [`MIPS_DMEM_WORDS];
        word_t     pc;
        word_t     next_pc;
        word_t     a;
        word_t     b;
        word_t     imm;
        word_t     res;
        word_t     addr;
        instr_t    ins;
        reg_addr_t dest;
        logic      wen;
        int        idx;
        exp_rd.delete();
        exp_data.delete();
        foreach (regs[i]) regs[i] = '0;
        foreach (dmem[i]) dmem[i] = '0;
        pc = `MIPS_RESET_PC;
        for (int steps = 0; steps < 1000; steps++) begin
            idx = int'(pc >> 2);
            if (idx >= prog.size()) begin
                break;
            end
            ins     = prog[idx];
            a       = regs[ins[25:21]];
            b       = regs[ins[20:16]];
            imm     = {{16{ins[15]}}, ins[15:0]};
            addr    = a + imm;
            next_pc = pc + 32'd4;
            dest    = ins[20:16];
            wen     = 1'b0;
            res     = '0;
            case (ins[31:26])
                `MIPS_OP_RTYPE: begin
                    dest = ins[15:11];
                    wen  = 1'b1;
                    case (ins[5:0])
                        `MIPS_FN_ADD: res = a + b;
                        `MIPS_FN_SUB: res = a - b;
                        `MIPS_FN_AND: res = a & b;
                        `MIPS_FN_OR:  res = a | b;
                        `MIPS_FN_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default:      wen = 1'b0;
                    endcase
                end
                `MIPS_OP_ADDI: begin
                    wen = 1'b1;
                    res = addr;
                end
                `MIPS_OP_LW: begin
                    wen = 1'b1;
                    res = dmem[int'((addr >> 2) % `MIPS_DMEM_WORDS)];
                end
                `MIPS_OP_SW: dmem[int'((addr >> 2) % `MIPS_DMEM_WORDS)] = b;
                `MIPS_OP_BEQ: begin
                    if (a == b) begin
                        next_pc = pc + 32'd4 + {imm[29:0], 2'b00};
                    end
                end
                default: wen = 1'b0;
            endcase
            if (wen && (dest != '0)) begin
                regs[dest] = res;
                exp_rd.push_back(dest);
                exp_data.push_back(res);
            end
            // Branch to self ends the program
            if (next_pc == pc) begin
                break;
            end
            pc = next_pc;
        end
    endtask

    task automatic check(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("ERR %s: got %h, expected %h", name, got, exp);
            test_errors++;
        end
    endtask

    ////////////////////////////////////////
    // Run one program on the core
    ////////////////////////////////////////
    task automatic run_program(input string name);
        int limit;
        int wait_max;
        int got;
        int waited;
        emit(itype(`MIPS_OP_BEQ, 0, 0, -1));
        build_expected();
        limit       = 5 * prog.size() + 40;
        wait_max    = limit - RESET_CYCLES - TAIL_CYCLES - 8;
        cycle_limit = cycle_limit + limit;
        test_errors = 0;
        @(negedge clk);
        rst_n = 1'b0;
        load_rom();
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        got    = 0;
        waited = 0;
        while ((got < exp_rd.size()) && (waited < wait_max)) begin
            @(negedge clk);
            waited++;
            if (wb_we) begin
                check("o_wb_rd", word_t'(wb_rd), word_t'(exp_rd[got]));
                check("o_wb_data", wb_data, exp_data[got]);
                got++;
            end
        end
        if (got < exp_rd.size()) begin
            $display("Test %s: only %0d of %0d register writes seen in time",
                     name, got, exp_rd.size());
            test_errors++;
        end else begin
            // Nothing may retire once the program sits in its final loop
            repeat (TAIL_CYCLES) begin
                @(negedge clk);
                if (wb_we) begin
                    $display("Test %s: unexpected write to register %0d after the end",
                             name, wb_rd);
                    test_errors++;
                end
            end
        end
        tests_run++;
        errors = errors + test_errors;
        $display("Test %s: %0d writes expected, %0d errors", name, exp_rd.size(),
                 test_errors);
    endtask

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////
    task automatic alu_ops();
        prog.delete();
        emit(itype(`MIPS_OP_ADDI, 1, 0, 100));
        emit(itype(`MIPS_OP_ADDI, 2, 0, -25));
        emit(itype(`MIPS_OP_ADDI, 3, 0, 'h0f0f));
        emit(itype(`MIPS_OP_ADDI, 4, 0, 'h7ff0));
        emit(rtype(`MIPS_FN_ADD, 5, 1, 2));
        emit(rtype(`MIPS_FN_SUB, 6, 1, 2));
        emit(rtype(`MIPS_FN_AND, 7, 3, 4));
        emit(rtype(`MIPS_FN_OR, 8, 3, 4));
        emit(rtype(`MIPS_FN_SLT, 9, 2, 1));
        emit(rtype(`MIPS_FN_SLT, 10, 1, 2));
        run_program("alu");
    endtask

    // Each result feeds the next one or two instructions
    task automatic forwarding_chain();
        prog.delete();
        emit(itype(`MIPS_OP_ADDI, 1, 0, 5));
        emit(rtype(`MIPS_FN_ADD, 2, 1, 1));
        emit(rtype(`MIPS_FN_SUB, 3, 2, 1));
        emit(rtype(`MIPS_FN_ADD, 4, 3, 2));
        emit(rtype(`MIPS_FN_ADD, 4, 4, 4));
        emit(rtype(`MIPS_FN_SUB, 5, 1, 4));
        emit(rtype(`MIPS_FN_OR, 6, 5, 3));
        emit(rtype(`MIPS_FN_AND, 7, 6, 5));
        run_program("forwarding");
    endtask

    task automatic load_use_stall();
        prog.delete();
        emit(itype(`MIPS_OP_ADDI, 1, 0, 'h123));
        emit(itype(`MIPS_OP_ADDI, 2, 0, -7));
        emit(itype(`MIPS_OP_ADDI, 3, 0, 8));
        emit(itype(`MIPS_OP_SW, 1, 3, 0));
        emit(itype(`MIPS_OP_SW, 2, 3, 4));
        emit(itype(`MIPS_OP_LW, 4, 3, 0));
        emit(itype(`MIPS_OP_LW, 5, 3, 4));
        emit(rtype(`MIPS_FN_ADD, 6, 5, 4));
        emit(itype(`MIPS_OP_SW, 6, 3, 8));
        emit(itype(`MIPS_OP_LW, 7, 3, 8));
        emit(rtype(`MIPS_FN_SUB, 7, 7, 1));
        run_program("load_use");
    endtask

    task automatic branch_flush();
        prog.delete();
        emit(itype(`MIPS_OP_ADDI, 1, 0, 3));
        emit(itype(`MIPS_OP_ADDI, 2, 0, 3));
        emit(itype(`MIPS_OP_BEQ, 2, 1, 3));
        // Skipped by the taken branch
        emit(itype(`MIPS_OP_ADDI, 3, 0, 1));
        emit(itype(`MIPS_OP_ADDI, 4, 0, 2));
        emit(itype(`MIPS_OP_ADDI, 5, 0, 3));
        emit(itype(`MIPS_OP_ADDI, 6, 0, 4));
        emit(itype(`MIPS_OP_BEQ, 6, 1, 1));
        emit(itype(`MIPS_OP_ADDI, 7, 0, 5));
        emit(itype(`MIPS_OP_ADDI, 0, 0, 9));
        emit(rtype(`MIPS_FN_ADD, 0, 1, 2));
        emit(itype(`MIPS_OP_ADDI, 8, 0, 6));
        run_program("branches");
    endtask

    task automatic random_program();
        int sel;
        int rd;
        int rs;
        int rt;
        prog.delete();
        repeat (40) begin
            sel = $random(seed) & 7;
            rd  = $random(seed) & 7;
            rs  = $random(seed) & 7;
            rt  = $random(seed) & 7;
            case (sel)
                0:       emit(rtype(`MIPS_FN_ADD, rd, rs, rt));
                1:       emit(rtype(`MIPS_FN_SUB, rd, rs, rt));
                2:       emit(rtype(`MIPS_FN_AND, rd, rs, rt));
                3:       emit(rtype(`MIPS_FN_OR, rd, rs, rt));
                4:       emit(rtype(`MIPS_FN_SLT, rd, rs, rt));
                default: emit(itype(`MIPS_OP_ADDI, rd, rs, $random(seed)));
            endcase
        end
        run_program("random");
    endtask

    initial begin
        int assert_fails;
        rst_n = 1'b0;
        alu_ops();
        forwarding_chain();
        load_use_stall();
        branch_flush();
        random_program();
        assert_fails = mips_core_i.u_checker.n_reset_fail +
                       mips_core_i.u_checker.n_wb_rd_fail +
                       mips_core_i.u_checker.n_pc_fail;
        errors = errors + assert_fails;
        $display("Tests run: %0d, errors: %0d, assertion failures: %0d",
                 tests_run, errors, assert_fails);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+logic
logic/mips_pkg.sv
logic/mips_decode.sv
logic/mips_regfile.sv
logic/mips_hazard.sv
logic/mips_execute.sv
logic/mips_dmem.sv
logic/mips_core.sv
testbench/mips_checker.sv
testbench/tb_mips_core.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the MIPS pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -f vlog.f --top-module tb_mips_core
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Keep running after an assertion error so the testbench can report
./obj_dir/Vtb_mips_core +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Finished with errors" "$LOG"; then
    echo "FAIL"
    exit 1
fi

echo "PASS"
exit 0
